// ==== design/io_pkg.sv ====
// Shared definitions for the memory-mapped I/O subsystem
// Only regions 1 and 2 are mapped and all other regions answer with zero

package io_pkg;

  // Bus types
  // --------------------
  typedef logic [31:0] io_addr_t;
  typedef logic [31:0] io_data_t;
  typedef logic [3:0]  io_strobe_t;
  typedef logic [4:0]  reg_offset_t;
  typedef logic [3:0]  region_t;
  typedef logic [63:0] timer_count_t;

  // Address fields
  localparam int REGION_MSB = 15;
  localparam int REGION_LSB = 12;
  localparam int OFFSET_MSB = 4;
  localparam int OFFSET_LSB = 0;

  // Region map
  // --------------------
  localparam region_t REGION_TIMER = 4'd1;
  localparam region_t REGION_GPIO  = 4'd2;

  // Timer registers
  localparam reg_offset_t TIMER_ENABLE_OFFSET       = 5'h00;
  localparam reg_offset_t TIMER_COUNTER_LOW_OFFSET  = 5'h04;
  localparam reg_offset_t TIMER_COUNTER_HIGH_OFFSET = 5'h08;
  localparam reg_offset_t TIMER_COMPARE_LOW_OFFSET  = 5'h0C;
  localparam reg_offset_t TIMER_COMPARE_HIGH_OFFSET = 5'h10;

  // GPIO registers
  localparam reg_offset_t GPIO_OUTPUT_OFFSET = 5'h00;
  localparam reg_offset_t GPIO_INPUT_OFFSET  = 5'h04;

  // Target whose response is due in the next cycle
  typedef enum logic [1:0] {
    TARGET_NONE,
    TARGET_TIMER,
    TARGET_GPIO,
    TARGET_UNMAPPED
  } target_t;

  // Only full word, low half and low byte strobes are accepted
  // The full data word is written in every accepted case
  function automatic logic strobe_is_valid(input io_strobe_t strobe);
    return (strobe == 4'b1111) || (strobe == 4'b0011) || (strobe == 4'b0001);
  endfunction

endpackage

// ==== design/io_bus_decoder.sv ====
// Routes one-cycle requests by address bits 15:12 and returns the response a cycle later
// Requests to unmapped regions are answered here with read data of zero

`timescale 1ns/1ps

module io_bus_decoder (
  input  logic                clock,
  input  logic                reset_n,

  // Core side
  input  io_pkg::io_addr_t    address,
  input  logic                read_request,
  input  logic                write_request,
  input  io_pkg::io_data_t    write_data,
  input  io_pkg::io_strobe_t  write_strobe,
  output io_pkg::io_data_t    read_data,
  output logic                read_response,
  output logic                write_response,

  // Shared peripheral side
  output io_pkg::reg_offset_t offset,
  output io_pkg::io_data_t    peripheral_write_data,
  output io_pkg::io_strobe_t  peripheral_write_strobe,

  // Timer
  output logic                timer_read_request,
  output logic                timer_write_request,
  input  io_pkg::io_data_t    timer_read_data,
  input  logic                timer_read_response,
  input  logic                timer_write_response,

  // GPIO
  output logic                gpio_read_request,
  output logic                gpio_write_request,
  input  io_pkg::io_data_t    gpio_read_data,
  input  logic                gpio_read_response,
  input  logic                gpio_write_response
);

  import io_pkg::*;

  region_t region;
  logic    timer_selected;
  logic    gpio_selected;
  logic    unmapped_selected;
  logic    mapped_write;
  target_t next_target;
  target_t pending_target;
  logic    unmapped_read_response;
  logic    unmapped_write_response;

  // Request decode
  // --------------------
  assign region            = address[REGION_MSB:REGION_LSB];
  assign offset            = address[OFFSET_MSB:OFFSET_LSB];
  assign timer_selected    = (region == REGION_TIMER);
  assign gpio_selected     = (region == REGION_GPIO);
  assign unmapped_selected = !timer_selected && !gpio_selected;

  assign timer_read_request  = read_request && timer_selected;
  assign timer_write_request = write_request && timer_selected;
  assign gpio_read_request   = read_request && gpio_selected;
  assign gpio_write_request  = write_request && gpio_selected;

  // Write payload is held at zero unless a mapped write is on the bus
  assign mapped_write            = write_request && !unmapped_selected;
  assign peripheral_write_data   = mapped_write ? write_data : '0;
  assign peripheral_write_strobe = mapped_write ? write_strobe : '0;

  always_comb begin
    next_target = TARGET_NONE;
    if (read_request || write_request) begin
      if (timer_selected) begin
        next_target = TARGET_TIMER;
      end else if (gpio_selected) begin
        next_target = TARGET_GPIO;
      end else begin
        next_target = TARGET_UNMAPPED;
      end
    end
  end

  // Pending target
  // --------------------
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      pending_target          <= TARGET_NONE;
      unmapped_read_response  <= 1'b0;
      unmapped_write_response <= 1'b0;
    end else begin
      pending_target          <= next_target;
      unmapped_read_response  <= read_request && unmapped_selected;
      unmapped_write_response <= write_request && unmapped_selected;
    end
  end

  // Response mux
  // --------------------
  always_comb begin
    read_data      = '0;
    read_response  = 1'b0;
    write_response = 1'b0;
    case (pending_target)
      TARGET_TIMER: begin
        read_data      = timer_read_data;
        read_response  = timer_read_response;
        write_response = timer_write_response;
      end
      TARGET_GPIO: begin
        read_data      = gpio_read_data;
        read_response  = gpio_read_response;
        write_response = gpio_write_response;
      end
      TARGET_UNMAPPED: begin
        // Zero data for unmapped reads
        read_response  = unmapped_read_response;
        write_response = unmapped_write_response;
      end
      default: begin
      end
    endcase
  end

endmodule

// ==== design/io_timer.sv ====
// 64-bit machine timer with compare interrupt whose registers are accessed one 32-bit half at a time
// Writes with a strobe other than 1111, 0011 or 0001 are dropped but still answered

`timescale 1ns/1ps

module io_timer (
  input  logic                clock,
  input  logic                reset_n,

  // Register bus
  input  io_pkg::reg_offset_t offset,
  input  logic                read_request,
  input  logic                write_request,
  input  io_pkg::io_data_t    write_data,
  input  io_pkg::io_strobe_t  write_strobe,
  output io_pkg::io_data_t    read_data,
  output logic                read_response,
  output logic                write_response,

  // Interrupt
  output logic                timer_irq
);

  import io_pkg::*;

  logic         counter_enable;
  timer_count_t counter;
  timer_count_t compare;
  logic         write_valid;
  logic         counter_low_write;
  logic         counter_high_write;

  assign write_valid        = write_request && strobe_is_valid(write_strobe);
  assign counter_low_write  = write_valid && (offset == TIMER_COUNTER_LOW_OFFSET);
  assign counter_high_write = write_valid && (offset == TIMER_COUNTER_HIGH_OFFSET);

  // Responses
  // --------------------
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      read_response  <= 1'b0;
      write_response <= 1'b0;
    end else begin
      read_response  <= read_request;
      write_response <= write_request;
    end
  end

  // Register readback
  // --------------------
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      read_data <= '0;
    end else if (read_request) begin
      case (offset)
        TIMER_ENABLE_OFFSET:       read_data <= {31'd0, counter_enable};
        TIMER_COUNTER_LOW_OFFSET:  read_data <= counter[31:0];
        TIMER_COUNTER_HIGH_OFFSET: read_data <= counter[63:32];
        TIMER_COMPARE_LOW_OFFSET:  read_data <= compare[31:0];
        TIMER_COMPARE_HIGH_OFFSET: read_data <= compare[63:32];
        default:                   read_data <= '0;
      endcase
    end
  end

  // Enable and compare registers
  // --------------------
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      counter_enable <= 1'b0;
      compare        <= '1;
    end else if (write_valid) begin
      case (offset)
        TIMER_ENABLE_OFFSET:       counter_enable <= write_data[0];
        TIMER_COMPARE_LOW_OFFSET:  compare[31:0]  <= write_data;
        TIMER_COMPARE_HIGH_OFFSET: compare[63:32] <= write_data;
        default: begin
        end
      endcase
    end
  end

  // Counter
  // --------------------
  // A write to either half takes priority and stalls the increment for that cycle
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      counter <= '0;
    end else if (counter_low_write) begin
      counter[31:0] <= write_data;
    end else if (counter_high_write) begin
      counter[63:32] <= write_data;
    end else if (counter_enable) begin
      counter <= counter + timer_count_t'(1);
    end
  end

  // Interrupt
  // --------------------
  // Level output that clears only once compare moves above the counter
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      timer_irq <= 1'b0;
    end else begin
      timer_irq <= (counter >= compare);
    end
  end

endmodule

// ==== design/io_gpio.sv ====
// GPIO port of 1 to 32 pins; inputs are synchronized in two flops before readback
// Output pins take the low gpio_width bits of an accepted write

`timescale 1ns/1ps

module io_gpio #(
  parameter int gpio_width = 8
) (
  input  logic                  clock,
  input  logic                  reset_n,

  // Register bus
  input  io_pkg::reg_offset_t   offset,
  input  logic                  read_request,
  input  logic                  write_request,
  input  io_pkg::io_data_t      write_data,
  input  io_pkg::io_strobe_t    write_strobe,
  output io_pkg::io_data_t      read_data,
  output logic                  read_response,
  output logic                  write_response,

  // Pins
  input  logic [gpio_width-1:0] gpio_in,
  output logic [gpio_width-1:0] gpio_out
);

  import io_pkg::*;

  logic [gpio_width-1:0] gpio_in_meta;
  logic [gpio_width-1:0] gpio_in_sync;
  io_data_t              output_word;
  io_data_t              input_word;

  // Responses
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      read_response  <= 1'b0;
      write_response <= 1'b0;
    end else begin
      read_response  <= read_request;
      write_response <= write_request;
    end
  end

  // Output register
  // --------------------
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      gpio_out <= '0;
    end else if (write_request && strobe_is_valid(write_strobe) &&
                 (offset == GPIO_OUTPUT_OFFSET)) begin
      gpio_out <= write_data[gpio_width-1:0];
    end
  end

  // Input synchronizer
  // --------------------
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      gpio_in_meta <= '0;
      gpio_in_sync <= '0;
    end else begin
      gpio_in_meta <= gpio_in;
      gpio_in_sync <= gpio_in_meta;
    end
  end

  // Readback zero-extended to the bus width
  always_comb begin
    output_word = '0;
    input_word  = '0;
    output_word[gpio_width-1:0] = gpio_out;
    input_word[gpio_width-1:0]  = gpio_in_sync;
  end

  always_ff @(posedge clock) begin
    if (!reset_n) begin
      read_data <= '0;
    end else if (read_request) begin
      case (offset)
        GPIO_OUTPUT_OFFSET: read_data <= output_word;
        GPIO_INPUT_OFFSET:  read_data <= input_word;
        default:            read_data <= '0;
      endcase
    end
  end

endmodule

// ==== design/io_subsystem.sv ====
// I/O subsystem top with decoder, machine timer and GPIO port
// Every request is answered one cycle later and there is no back-pressure

`timescale 1ns/1ps

module io_subsystem #(
  parameter int gpio_width = 8
) (
  input  logic                  clock,
  input  logic                  reset_n,

  // Core bus
  input  io_pkg::io_addr_t      address,
  input  logic                  read_request,
  input  logic                  write_request,
  input  io_pkg::io_data_t      write_data,
  input  io_pkg::io_strobe_t    write_strobe,
  output io_pkg::io_data_t      read_data,
  output logic                  read_response,
  output logic                  write_response,

  // Peripheral pins
  output logic                  timer_irq,
  input  logic [gpio_width-1:0] gpio_in,
  output logic [gpio_width-1:0] gpio_out
);

  import io_pkg::*;

  // Internal bus
  // --------------------
  reg_offset_t offset;
  io_data_t    peripheral_write_data;
  io_strobe_t  peripheral_write_strobe;

  logic        timer_read_request;
  logic        timer_write_request;
  io_data_t    timer_read_data;
  logic        timer_read_response;
  logic        timer_write_response;

  logic        gpio_read_request;
  logic        gpio_write_request;
  io_data_t    gpio_read_data;
  logic        gpio_read_response;
  logic        gpio_write_response;

  io_bus_decoder u_decoder (
    .clock                   (clock),
    .reset_n                 (reset_n),
    .address                 (address),
    .read_request            (read_request),
    .write_request           (write_request),
    .write_data              (write_data),
    .write_strobe            (write_strobe),
    .read_data               (read_data),
    .read_response           (read_response),
    .write_response          (write_response),
    .offset                  (offset),
    .peripheral_write_data   (peripheral_write_data),
    .peripheral_write_strobe (peripheral_write_strobe),
    .timer_read_request      (timer_read_request),
    .timer_write_request     (timer_write_request),
    .timer_read_data         (timer_read_data),
    .timer_read_response     (timer_read_response),
    .timer_write_response    (timer_write_response),
    .gpio_read_request       (gpio_read_request),
    .gpio_write_request      (gpio_write_request),
    .gpio_read_data          (gpio_read_data),
    .gpio_read_response      (gpio_read_response),
    .gpio_write_response     (gpio_write_response)
  );

  io_timer u_timer (
    .clock          (clock),
    .reset_n        (reset_n),
    .offset         (offset),
    .read_request   (timer_read_request),
    .write_request  (timer_write_request),
    .write_data     (peripheral_write_data),
    .write_strobe   (peripheral_write_strobe),
    .read_data      (timer_read_data),
    .read_response  (timer_read_response),
    .write_response (timer_write_response),
    .timer_irq      (timer_irq)
  );

  io_gpio #(
    .gpio_width (gpio_width)
  ) u_gpio (
    .clock          (clock),
    .reset_n        (reset_n),
    .offset         (offset),
    .read_request   (gpio_read_request),
    .write_request  (gpio_write_request),
    .write_data     (peripheral_write_data),
    .write_strobe   (peripheral_write_strobe),
    .read_data      (gpio_read_data),
    .read_response  (gpio_read_response),
    .write_response (gpio_write_response),
    .gpio_in        (gpio_in),
    .gpio_out       (gpio_out)
  );

endmodule

// ==== dv/io_subsystem_tb.sv ====
// Directed testbench that plays the core on the one-cycle request/response bus
// Stops at the first error; gpio_width is fixed at 8

`timescale 1ns/1ps

module io_subsystem_tb;

  import io_pkg::*;

  localparam int      GPIO_WIDTH      = 8;
  localparam int      NUM_TESTS       = 6;
  localparam int      CYCLES_PER_TEST = 2000;
  localparam region_t REGION_UNMAPPED = 4'd5;

  logic                  clock;
  logic                  reset_n;
  io_addr_t              address;
  logic                  read_request;
  logic                  write_request;
  io_data_t              write_data;
  io_strobe_t            write_strobe;
  io_data_t              read_data;
  logic                  read_response;
  logic                  write_response;
  logic                  timer_irq;
  logic [GPIO_WIDTH-1:0] gpio_in;
  logic [GPIO_WIDTH-1:0] gpio_out;
  string                 current_test;

  io_subsystem #(
    .gpio_width (GPIO_WIDTH)
  ) dut (
    .clock          (clock),
    .reset_n        (reset_n),
    .address        (address),
    .read_request   (read_request),
    .write_request  (write_request),
    .write_data     (write_data),
    .write_strobe   (write_strobe),
    .read_data      (read_data),
    .read_response  (read_response),
    .write_response (write_response),
    .timer_irq      (timer_irq),
    .gpio_in        (gpio_in),
    .gpio_out       (gpio_out)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // Watchdog
  initial begin
    repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clock);
    $display("Timeout: tests did not finish within %0d cycles", NUM_TESTS * CYCLES_PER_TEST);
    $display("STATUS: FAIL");
    $fatal(1, "Watchdog expired");
  end

  // Checking helpers
  // --------------------
  task automatic stop_with_error(input string reason);
    $display("Error in %s: %s", current_test, reason);
    $display("STATUS: FAIL");
    $fatal(1, "Stopping at first error");
  endtask

  task automatic check_value(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      $display("Mismatch in %s (%s): expected 0x%0h, actual 0x%0h",
               current_test, what, expected, actual);
      $display("STATUS: FAIL");
      $fatal(1, "Stopping at first error");
    end
  endtask

  // Region in bits 15:12, register offset in bits 4:0
  function automatic io_addr_t make_address(input region_t region, input reg_offset_t reg_offset);
    return {16'd0, region, 7'd0, reg_offset};
  endfunction

  function automatic io_strobe_t pick_valid_strobe();
    case ($urandom_range(2))
      0:       return 4'b1111;
      1:       return 4'b0011;
      default: return 4'b0001;
    endcase
  endfunction

  // Bus transactions
  // --------------------
  task automatic bus_write(input io_addr_t addr, input io_data_t data, input io_strobe_t strobe);
    @(posedge clock);
    address       <= addr;
    write_data    <= data;
    write_strobe  <= strobe;
    write_request <= 1'b1;
    @(negedge clock);
    if (write_response) stop_with_error("write response came in the request cycle");
    @(posedge clock);
    write_request <= 1'b0;
    write_data    <= '0;
    write_strobe  <= '0;
    @(negedge clock);
    if (!write_response) stop_with_error("no write response one cycle after the request");
  endtask

  task automatic bus_read(input io_addr_t addr, output io_data_t data);
    @(posedge clock);
    address      <= addr;
    read_request <= 1'b1;
    @(negedge clock);
    if (read_response) stop_with_error("read response came in the request cycle");
    @(posedge clock);
    read_request <= 1'b0;
    @(negedge clock);
    if (!read_response) stop_with_error("no read response one cycle after the request");
    data = read_data;
  endtask

  // Tests
  // --------------------
  task automatic test_reset_values();
    io_data_t value;
    current_test = "reset_values";
    @(negedge clock);
    check_value("timer_irq", 0, timer_irq);
    check_value("gpio_out", 0, gpio_out);
    check_value("read_data", 0, read_data);
    check_value("responses", 0, {read_response, write_response});
    bus_read(make_address(REGION_TIMER, TIMER_ENABLE_OFFSET), value);
    check_value("enable", 0, value);
    bus_read(make_address(REGION_TIMER, TIMER_COUNTER_LOW_OFFSET), value);
    check_value("counter low", 0, value);
    bus_read(make_address(REGION_TIMER, TIMER_COUNTER_HIGH_OFFSET), value);
    check_value("counter high", 0, value);
    bus_read(make_address(REGION_TIMER, TIMER_COMPARE_LOW_OFFSET), value);
    check_value("compare low", 32'hFFFF_FFFF, value);
    bus_read(make_address(REGION_TIMER, TIMER_COMPARE_HIGH_OFFSET), value);
    check_value("compare high", 32'hFFFF_FFFF, value);
  endtask

  // Timer is still disabled here, so the counter halves hold what was written
  task automatic test_register_readback();
    reg_offset_t offsets [4];
    io_data_t    written [4];
    io_data_t    value;
    current_test = "register_readback";
    offsets = '{TIMER_COMPARE_LOW_OFFSET, TIMER_COMPARE_HIGH_OFFSET,
                TIMER_COUNTER_LOW_OFFSET, TIMER_COUNTER_HIGH_OFFSET};
    for (int i = 0; i < 4; i++) begin
      written[i] = $urandom;
      bus_write(make_address(REGION_TIMER, offsets[i]), written[i], pick_valid_strobe());
    end
    for (int i = 0; i < 4; i++) begin
      bus_read(make_address(REGION_TIMER, offsets[i]), value);
      check_value("readback", written[i], value);
    end
    // Strobe 0101 is not an accepted pattern
    bus_write(make_address(REGION_TIMER, offsets[0]), ~written[0], 4'b0101);
    bus_read(make_address(REGION_TIMER, offsets[0]), value);
    check_value("ignored strobe", written[0], value);
  endtask

  task automatic test_counting();
    io_data_t first;
    io_data_t second;
    current_test = "counting";
    bus_write(make_address(REGION_TIMER, TIMER_COUNTER_LOW_OFFSET), 0, 4'b1111);
    bus_write(make_address(REGION_TIMER, TIMER_COUNTER_HIGH_OFFSET), 0, 4'b1111);
    bus_write(make_address(REGION_TIMER, TIMER_ENABLE_OFFSET), 1, 4'b1111);
    bus_read(make_address(REGION_TIMER, TIMER_COUNTER_LOW_OFFSET), first);
    bus_read(make_address(REGION_TIMER, TIMER_COUNTER_LOW_OFFSET), second);
    check_value("counter increases", 1, second > first);
    bus_write(make_address(REGION_TIMER, TIMER_ENABLE_OFFSET), 0, 4'b1111);
    bus_read(make_address(REGION_TIMER, TIMER_COUNTER_LOW_OFFSET), first);
    bus_read(make_address(REGION_TIMER, TIMER_COUNTER_LOW_OFFSET), second);
    check_value("counter holds", first, second);
  endtask

  task automatic test_interrupt();
    current_test = "interrupt";
    bus_write(make_address(REGION_TIMER, TIMER_COUNTER_LOW_OFFSET), 100, 4'b1111);
    bus_write(make_address(REGION_TIMER, TIMER_COUNTER_HIGH_OFFSET), 0, 4'b1111);
    bus_write(make_address(REGION_TIMER, TIMER_COMPARE_LOW_OFFSET), 105, 4'b1111);
    bus_write(make_address(REGION_TIMER, TIMER_COMPARE_HIGH_OFFSET), 0, 4'b1111);
    repeat (2) @(negedge clock);
    check_value("irq while below compare", 0, timer_irq);
    bus_write(make_address(REGION_TIMER, TIMER_ENABLE_OFFSET), 1, 4'b1111);
    for (int cycle = 0; cycle < 20 && !timer_irq; cycle++) @(negedge clock);
    if (!timer_irq) stop_with_error("timer_irq did not rise within 20 cycles");
    repeat (10) begin
      @(negedge clock);
      check_value("irq held", 1, timer_irq);
    end
    // Compare back to all ones releases the interrupt
    bus_write(make_address(REGION_TIMER, TIMER_COMPARE_HIGH_OFFSET), 32'hFFFF_FFFF, 4'b1111);
    bus_write(make_address(REGION_TIMER, TIMER_COMPARE_LOW_OFFSET), 32'hFFFF_FFFF, 4'b1111);
    repeat (2) @(negedge clock);
    check_value("irq cleared", 0, timer_irq);
    bus_write(make_address(REGION_TIMER, TIMER_ENABLE_OFFSET), 0, 4'b1111);
  endtask

  task automatic test_gpio();
    io_data_t              value;
    io_data_t              readback;
    logic [GPIO_WIDTH-1:0] pins;
    current_test = "gpio";
    for (int i = 0; i < 4; i++) begin
      value = $urandom;
      bus_write(make_address(REGION_GPIO, GPIO_OUTPUT_OFFSET), value, pick_valid_strobe());
      check_value("gpio_out", value[GPIO_WIDTH-1:0], gpio_out);
      bus_read(make_address(REGION_GPIO, GPIO_OUTPUT_OFFSET), readback);
      check_value("output readback", value[GPIO_WIDTH-1:0], readback);
    end
    bus_write(make_address(REGION_GPIO, GPIO_OUTPUT_OFFSET), ~value, 4'b0101);
    check_value("gpio_out after ignored write", value[GPIO_WIDTH-1:0], gpio_out);
    // Two synchronizer stages delay the pins before readback
    pins = $urandom;
    @(posedge clock);
    gpio_in <= pins;
    for (int poll = 0; poll < 3; poll++) begin
      bus_read(make_address(REGION_GPIO, GPIO_INPUT_OFFSET), readback);
      if (readback == 32'(pins)) break;
    end
    check_value("input readback", pins, readback);
  endtask

  task automatic test_unmapped();
    io_data_t compare_low;
    io_data_t output_word;
    io_data_t value;
    current_test = "unmapped";
    compare_low = $urandom;
    output_word = $urandom;
    // Known contents in both peripherals before the unmapped accesses
    bus_write(make_address(REGION_TIMER, TIMER_COMPARE_LOW_OFFSET), compare_low, 4'b1111);
    bus_write(make_address(REGION_GPIO, GPIO_OUTPUT_OFFSET), output_word, 4'b1111);
    bus_read(make_address(REGION_UNMAPPED, 5'h00), value);
    check_value("unmapped read", 0, value);
    bus_read(make_address(REGION_UNMAPPED, TIMER_COMPARE_LOW_OFFSET), value);
    check_value("unmapped read", 0, value);
    // Bit 0 set and low byte different from the GPIO output register
    bus_write(make_address(REGION_UNMAPPED, 5'h00), ~output_word | 32'd1, 4'b1111);
    bus_write(make_address(REGION_UNMAPPED, TIMER_COMPARE_LOW_OFFSET), ~compare_low, 4'b1111);
    bus_read(make_address(REGION_TIMER, TIMER_ENABLE_OFFSET), value);
    check_value("timer enable", 0, value);
    bus_read(make_address(REGION_TIMER, TIMER_COMPARE_LOW_OFFSET), value);
    check_value("timer compare low", compare_low, value);
    bus_read(make_address(REGION_GPIO, GPIO_OUTPUT_OFFSET), value);
    check_value("gpio output", 32'(output_word[GPIO_WIDTH-1:0]), value);
  endtask

  // Main sequence
  // --------------------
  initial begin
    void'($urandom(32'h7f97cfc0));
    current_test  = "reset";
    reset_n       = 1'b0;
    address       = '0;
    read_request  = 1'b0;
    write_request = 1'b0;
    write_data    = '0;
    write_strobe  = '0;
    gpio_in       = '0;
    repeat (4) @(posedge clock);
    reset_n <= 1'b1;

    test_reset_values();
    test_register_readback();
    test_counting();
    test_interrupt();
    test_gpio();
    test_unmapped();

    $display("STATUS: PASS");
    $finish;
  end

endmodule

// ==== compile.f ====
design/io_pkg.sv
design/io_bus_decoder.sv
design/io_timer.sv
design/io_gpio.sv
design/io_subsystem.sv
dv/io_subsystem_tb.sv

// ==== Bender.yml ====
package:
  name: io_subsystem

sources:
  # Package first, then the peripherals and the top level
  - files:
      - design/io_pkg.sv
      - design/io_bus_decoder.sv
      - design/io_timer.sv
      - design/io_gpio.sv
      - design/io_subsystem.sv
  - target: simulation
    files:
      - dv/io_subsystem_tb.sv
